//--- hdl/fl_cfg_pkg.sv
package fl_cfg_pkg;

  // Pointer and list sizes
  localparam int PTR_W     = 5;
  localparam int NUM_PTR   = 16;
  localparam int RAM_AW    = 4;
  localparam int RAM_DEPTH = 16;

  // Free count runs from 0 up to NUM_PTR
  localparam int CNT_W = 5;

  // RAM read pipeline depth
  localparam int RD_LAT = 2;

  // Enough entries to keep pops going while reads are in flight
  localparam int PF_DEPTH = RD_LAT + 2;

  typedef logic [PTR_W-1:0] fl_ptr_t;

  typedef logic [CNT_W-1:0] fl_cnt_t;

  typedef logic [RAM_AW-1:0] fl_idx_t;

endpackage

//--- hdl/fl_cpu_pkg.sv
package fl_cpu_pkg;

  // Address is {region, ram index}
  localparam int CPU_AW = 5;
  localparam int CPU_DW = 8;

  // Region bit values, cpu_addr[CPU_AW-1]
  localparam logic REG_FREECNT = 1'b0;
  localparam logic REG_ENTRY   = 1'b1;

  // One data word, seen as the free count or as a pointer
  typedef union packed {
    struct packed {
      logic [CPU_DW-fl_cfg_pkg::CNT_W-1:0] pad;
      fl_cfg_pkg::fl_cnt_t                 cnt;
    } as_cnt;
    struct packed {
      logic [CPU_DW-fl_cfg_pkg::PTR_W-1:0] pad;
      fl_cfg_pkg::fl_ptr_t                 ptr;
    } as_ptr;
  } cpu_word_u;

endpackage

//--- hdl/fl_ptr_ram.sv
`timescale 1ns/1ps

module fl_ptr_ram (
  input  logic                clk,
  input  logic                wr_en,
  input  fl_cfg_pkg::fl_idx_t wr_idx,
  input  fl_cfg_pkg::fl_ptr_t wr_ptr,
  input  logic                rd_en,
  input  fl_cfg_pkg::fl_idx_t rd_idx,
  output fl_cfg_pkg::fl_ptr_t rd_ptr
);
  import fl_cfg_pkg::*;

  fl_ptr_t mem [RAM_DEPTH];
  fl_ptr_t rd_pipe [RD_LAT];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx] <= wr_ptr;
    end
  end

  // First stage loads on a read, later stages just carry the word along
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_pipe[0] <= mem[rd_idx];
    end
    for (int i = 1; i < RD_LAT; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign rd_ptr = rd_pipe[RD_LAT-1];

  a_idx_range: assert property (
    @(posedge clk)
    (wr_en |-> !$isunknown(wr_idx) && (int'(wr_idx) < RAM_DEPTH)) and
    (rd_en |-> !$isunknown(rd_idx) && (int'(rd_idx) < RAM_DEPTH))
  );

endmodule

//--- hdl/fl_level_cnt.sv
`timescale 1ns/1ps

module fl_level_cnt (
  input  logic                clk,
  input  logic                rstvld,
  input  logic                init_step,
  input  logic                push,
  input  logic                rd_issue,
  input  logic                pop_take,
  output fl_cfg_pkg::fl_idx_t head_idx,
  output fl_cfg_pkg::fl_idx_t tail_idx,
  output logic                ram_empty,
  output logic                init_last,
  output fl_cfg_pkg::fl_cnt_t free_cnt
);
  import fl_cfg_pkg::*;

  fl_cnt_t ram_occ;
  logic    put;

  // Init and push both append at the tail
  assign put = init_step || push;

  assign ram_empty = (ram_occ == '0);
  assign init_last = init_step && (tail_idx == fl_idx_t'(RAM_DEPTH - 1));

  always_ff @(posedge clk) begin
    if (rstvld) begin
      head_idx <= '0;
      tail_idx <= '0;
      ram_occ  <= '0;
      free_cnt <= '0;
    end else begin
      if (put) begin
        tail_idx <= tail_idx + 1'b1;
      end
      if (rd_issue) begin
        head_idx <= head_idx + 1'b1;
      end
      // RAM occupancy drops when a read leaves for the prefetch buffer
      ram_occ  <= ram_occ + fl_cnt_t'(put) - fl_cnt_t'(rd_issue);
      // Free count drops only when a client takes a pointer
      free_cnt <= free_cnt + fl_cnt_t'(put) - fl_cnt_t'(pop_take);
    end
  end

  a_push_bound: assert property (
    @(posedge clk) disable iff (rstvld)
    push |=> (free_cnt <= fl_cnt_t'(NUM_PTR))
  );

endmodule

//--- hdl/fl_prefetch.sv
`timescale 1ns/1ps

module fl_prefetch (
  input  logic                clk,
  input  logic                rstvld,
  input  logic                pop,
  input  logic                ready,
  input  logic                rd_allow,
  input  logic                ram_empty,
  input  fl_cfg_pkg::fl_ptr_t ram_rd_ptr,
  output logic                pop_vld,
  output fl_cfg_pkg::fl_ptr_t pop_ptr,
  output logic                pop_take,
  output logic                rd_issue,
  output logic                rd_busy
);
  import fl_cfg_pkg::*;

  fl_ptr_t                       pf_mem [PF_DEPTH];
  logic [$clog2(PF_DEPTH)-1:0]   pf_wr;
  logic [$clog2(PF_DEPTH)-1:0]   pf_rd;
  logic [$clog2(PF_DEPTH+1)-1:0] pf_cnt;
  logic [RD_LAT-1:0]             rd_tag;
  logic                          rd_land;
  int                            pf_used;

  // Slots already taken, counting reads that have not landed yet
  assign pf_used  = int'(pf_cnt) + $countones(rd_tag);
  assign rd_issue = rd_allow && !ram_empty && (pf_used < PF_DEPTH);
  assign rd_busy  = |rd_tag;
  assign rd_land  = rd_tag[RD_LAT-1];

  assign pop_vld  = pop && ready && (pf_cnt != '0);
  assign pop_take = pop_vld;
  assign pop_ptr  = pf_mem[pf_rd];

  always_ff @(posedge clk) begin
    if (rstvld) begin
      pf_wr  <= '0;
      pf_rd  <= '0;
      pf_cnt <= '0;
      rd_tag <= '0;
    end else begin
      rd_tag <= {rd_tag[RD_LAT-2:0], rd_issue};
      if (rd_land) begin
        pf_wr <= pf_wr + 1'b1;
      end
      if (pop_take) begin
        pf_rd <= pf_rd + 1'b1;
      end
      case ({rd_land, pop_take})
        2'b10:   pf_cnt <= pf_cnt + 1'b1;
        2'b01:   pf_cnt <= pf_cnt - 1'b1;
        default: pf_cnt <= pf_cnt;
      endcase
    end
  end

  // Tag reaches the end together with the RAM data
  always_ff @(posedge clk) begin
    if (rd_land) begin
      pf_mem[pf_wr] <= ram_rd_ptr;
    end
  end

  a_pf_room: assert property (
    @(posedge clk) disable iff (rstvld)
    pf_used <= PF_DEPTH
  );

endmodule

//--- hdl/fl_ram_access.sv
`timescale 1ns/1ps

module fl_ram_access (
  input  logic                          clk,
  input  logic                          init_step,
  input  fl_cfg_pkg::fl_idx_t           tail_idx,
  input  fl_cfg_pkg::fl_idx_t           head_idx,
  input  logic                          push,
  input  fl_cfg_pkg::fl_ptr_t           push_ptr,
  input  logic                          rd_issue,
  input  logic                          cpu_go,
  input  logic                          cpu_wr,
  input  logic [fl_cpu_pkg::CPU_AW-1:0] cpu_addr,
  input  fl_cpu_pkg::cpu_word_u         cpu_wdata,
  input  fl_cfg_pkg::fl_cnt_t           free_cnt,
  input  fl_cfg_pkg::fl_ptr_t           ram_rd_ptr,
  output logic                          ram_wr_en,
  output fl_cfg_pkg::fl_idx_t           ram_wr_idx,
  output fl_cfg_pkg::fl_ptr_t           ram_wr_ptr,
  output logic                          ram_rd_en,
  output fl_cfg_pkg::fl_idx_t           ram_rd_idx,
  output fl_cpu_pkg::cpu_word_u         cpu_rdata,
  output logic                          cpu_done
);
  import fl_cfg_pkg::*;
  import fl_cpu_pkg::*;

  fl_idx_t           cpu_idx;
  logic              entry_wr;
  logic              entry_rd;
  logic              cnt_rd;
  logic [RD_LAT-1:0] cpu_tag;

  assign cpu_idx  = cpu_addr[RAM_AW-1:0];
  assign entry_wr = cpu_go && (cpu_addr[CPU_AW-1] == REG_ENTRY) && cpu_wr;
  assign entry_rd = cpu_go && (cpu_addr[CPU_AW-1] == REG_ENTRY) && !cpu_wr;
  // Count writes are acked but dropped
  assign cnt_rd   = cpu_go && (cpu_addr[CPU_AW-1] == REG_FREECNT) && !cpu_wr;

  // Write port: init first, then CPU, then push at the tail
  always_comb begin
    ram_wr_en  = init_step || push || entry_wr;
    ram_wr_idx = tail_idx;
    ram_wr_ptr = push_ptr;
    if (init_step) begin
      ram_wr_ptr = fl_ptr_t'(tail_idx);
    end else if (entry_wr) begin
      ram_wr_idx = cpu_idx;
      ram_wr_ptr = cpu_wdata.as_ptr.ptr;
    end
  end

  assign ram_rd_en  = rd_issue || entry_rd;
  assign ram_rd_idx = entry_rd ? cpu_idx : head_idx;

  always_ff @(posedge clk) begin
    cpu_tag  <= {cpu_tag[RD_LAT-2:0], entry_rd};
    cpu_done <= (cpu_go && !entry_rd) || cpu_tag[RD_LAT-1];
  end

  always_ff @(posedge clk) begin
    if (cnt_rd) begin
      cpu_rdata.as_cnt.pad <= '0;
      cpu_rdata.as_cnt.cnt <= free_cnt;
    end else if (cpu_tag[RD_LAT-1]) begin
      cpu_rdata.as_ptr.pad <= '0;
      cpu_rdata.as_ptr.ptr <= ram_rd_ptr;
    end
  end

endmodule

//--- hdl/fl_ctrl_fsm.sv
`timescale 1ns/1ps

module fl_ctrl_fsm (
  input  logic clk,
  input  logic rstvld,
  input  logic init_last,
  input  logic cpu_req,
  input  logic cpu_entry,
  input  logic cpu_done,
  input  logic rd_busy,
  output logic init_step,
  output logic ready,
  output logic rd_allow,
  output logic cpu_go,
  output logic cpu_ack
);
  import fl_cpu_pkg::*;

  enum logic [2:0] {INIT, RUN, CPU_DRAIN, CPU_WAIT, CPU_ACK} state, state_nxt;
  logic entry_req;

  assign entry_req = (cpu_entry == REG_ENTRY);

  always_comb begin
    state_nxt = state;
    cpu_go    = 1'b0;
    case (state)
      INIT: begin
        if (init_last) begin
          state_nxt = RUN;
        end
      end
      RUN: begin
        if (cpu_req && entry_req) begin
          state_nxt = CPU_DRAIN;
        end else if (cpu_req) begin
          cpu_go    = 1'b1;
          state_nxt = CPU_WAIT;
        end
      end
      // Let the prefetch reads land before the CPU takes the RAM
      CPU_DRAIN: begin
        if (!rd_busy) begin
          cpu_go    = 1'b1;
          state_nxt = CPU_WAIT;
        end
      end
      CPU_WAIT: begin
        if (cpu_done) begin
          state_nxt = CPU_ACK;
        end
      end
      CPU_ACK: begin
        if (!cpu_req) begin
          state_nxt = RUN;
        end
      end
      default: state_nxt = INIT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rstvld) begin
      state <= INIT;
    end else begin
      state <= state_nxt;
    end
  end

  assign init_step = (state == INIT);
  assign rd_allow  = (state == RUN);
  assign cpu_ack   = (state == CPU_ACK);
  // RAM ports go to the CPU for one cycle, so no push then
  assign ready     = (state != INIT) && !(cpu_go && entry_req);

  a_ack_rise: assert property (
    @(posedge clk) disable iff (rstvld)
    $rose(cpu_ack) |-> cpu_req
  );

endmodule

//--- hdl/fl_top.sv
`timescale 1ns/1ps

module fl_top (
  input  logic                          clk,
  input  logic                          rstvld,
  input  logic                          pop,
  output logic                          pop_vld,
  output fl_cfg_pkg::fl_ptr_t           pop_ptr,
  input  logic                          push,
  input  fl_cfg_pkg::fl_ptr_t           push_ptr,
  output fl_cfg_pkg::fl_cnt_t           free_cnt,
  output logic                          ready,
  input  logic                          cpu_req,
  input  logic                          cpu_wr,
  input  logic [fl_cpu_pkg::CPU_AW-1:0] cpu_addr,
  input  fl_cpu_pkg::cpu_word_u         cpu_wdata,
  output logic                          cpu_ack,
  output fl_cpu_pkg::cpu_word_u         cpu_rdata
);
  import fl_cfg_pkg::*;
  import fl_cpu_pkg::*;

  logic    init_step;
  logic    init_last;
  logic    rd_allow;
  logic    rd_issue;
  logic    rd_busy;
  logic    ram_empty;
  logic    pop_take;
  logic    cpu_go;
  logic    cpu_done;
  fl_idx_t head_idx;
  fl_idx_t tail_idx;
  logic    ram_wr_en;
  fl_idx_t ram_wr_idx;
  fl_ptr_t ram_wr_ptr;
  logic    ram_rd_en;
  fl_idx_t ram_rd_idx;
  fl_ptr_t ram_rd_ptr;

  fl_ctrl_fsm u_ctrl (
    .clk       (clk),
    .rstvld    (rstvld),
    .init_last (init_last),
    .cpu_req   (cpu_req),
    .cpu_entry (cpu_addr[CPU_AW-1]),
    .cpu_done  (cpu_done),
    .rd_busy   (rd_busy),
    .init_step (init_step),
    .ready     (ready),
    .rd_allow  (rd_allow),
    .cpu_go    (cpu_go),
    .cpu_ack   (cpu_ack)
  );

  fl_level_cnt u_level (
    .clk       (clk),
    .rstvld    (rstvld),
    .init_step (init_step),
    .push      (push),
    .rd_issue  (rd_issue),
    .pop_take  (pop_take),
    .head_idx  (head_idx),
    .tail_idx  (tail_idx),
    .ram_empty (ram_empty),
    .init_last (init_last),
    .free_cnt  (free_cnt)
  );

  fl_prefetch u_prefetch (
    .clk        (clk),
    .rstvld     (rstvld),
    .pop        (pop),
    .ready      (ready),
    .rd_allow   (rd_allow),
    .ram_empty  (ram_empty),
    .ram_rd_ptr (ram_rd_ptr),
    .pop_vld    (pop_vld),
    .pop_ptr    (pop_ptr),
    .pop_take   (pop_take),
    .rd_issue   (rd_issue),
    .rd_busy    (rd_busy)
  );

  fl_ram_access u_access (
    .clk        (clk),
    .init_step  (init_step),
    .tail_idx   (tail_idx),
    .head_idx   (head_idx),
    .push       (push),
    .push_ptr   (push_ptr),
    .rd_issue   (rd_issue),
    .cpu_go     (cpu_go),
    .cpu_wr     (cpu_wr),
    .cpu_addr   (cpu_addr),
    .cpu_wdata  (cpu_wdata),
    .free_cnt   (free_cnt),
    .ram_rd_ptr (ram_rd_ptr),
    .ram_wr_en  (ram_wr_en),
    .ram_wr_idx (ram_wr_idx),
    .ram_wr_ptr (ram_wr_ptr),
    .ram_rd_en  (ram_rd_en),
    .ram_rd_idx (ram_rd_idx),
    .cpu_rdata  (cpu_rdata),
    .cpu_done   (cpu_done)
  );

  fl_ptr_ram u_ram (
    .clk    (clk),
    .wr_en  (ram_wr_en),
    .wr_idx (ram_wr_idx),
    .wr_ptr (ram_wr_ptr),
    .rd_en  (ram_rd_en),
    .rd_idx (ram_rd_idx),
    .rd_ptr (ram_rd_ptr)
  );

  // A push needs the list running and a pointer actually out
  a_push_legal: assert property (
    @(posedge clk) disable iff (rstvld)
    push |-> ready && (free_cnt < fl_cnt_t'(NUM_PTR))
  );

endmodule

//--- tb/fl_top_tb.sv
`timescale 1ns/1ps

module fl_top_tb;
  import fl_cfg_pkg::*;
  import fl_cpu_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int DRV        = 2;
  localparam int POP_WAIT   = 10;
  localparam int EMPTY_HOLD = 6;
  localparam int ACK_WAIT   = 16;

  typedef enum logic [2:0] {
    OP_POP, OP_PUSH, OP_POP_PUSH, OP_CNT_RD, OP_ENT_WR, OP_ENT_RD
  } op_kind_e;

  // restore writes back the entry value saved by the last plain entry write
  typedef struct packed {
    op_kind_e   kind;
    logic [4:0] rep;
    fl_idx_t    idx;
    fl_ptr_t    ptr;
    logic       restore;
  } op_t;

  localparam int N_OPS = 18;
  localparam op_t OPS [N_OPS] = '{
    '{OP_POP,      5'd16, 4'd0, 5'd0,  1'b0},
    '{OP_POP,      5'd1,  4'd0, 5'd0,  1'b0},
    '{OP_CNT_RD,   5'd1,  4'd0, 5'd0,  1'b0},
    '{OP_PUSH,     5'd6,  4'd0, 5'd0,  1'b0},
    '{OP_POP,      5'd2,  4'd0, 5'd0,  1'b0},
    '{OP_PUSH,     5'd8,  4'd0, 5'd0,  1'b0},
    '{OP_POP_PUSH, 5'd5,  4'd0, 5'd0,  1'b0},
    '{OP_CNT_RD,   5'd1,  4'd0, 5'd0,  1'b0},
    '{OP_ENT_RD,   5'd1,  4'd5, 5'd0,  1'b0},
    '{OP_ENT_WR,   5'd1,  4'd5, 5'd27, 1'b0},
    '{OP_ENT_RD,   5'd1,  4'd5, 5'd0,  1'b0},
    '{OP_ENT_WR,   5'd1,  4'd5, 5'd0,  1'b1},
    '{OP_ENT_RD,   5'd1,  4'd5, 5'd0,  1'b0},
    '{OP_POP,      5'd12, 4'd0, 5'd0,  1'b0},
    '{OP_POP,      5'd1,  4'd0, 5'd0,  1'b0},
    '{OP_PUSH,     5'd16, 4'd0, 5'd0,  1'b0},
    '{OP_CNT_RD,   5'd1,  4'd0, 5'd0,  1'b0},
    '{OP_POP,      5'd16, 4'd0, 5'd0,  1'b0}
  };

  logic              clk;
  logic              rstvld;
  logic              pop;
  logic              pop_vld;
  fl_ptr_t           pop_ptr;
  logic              push;
  fl_ptr_t           push_ptr;
  fl_cnt_t           free_cnt;
  logic              ready;
  logic              cpu_req;
  logic              cpu_wr;
  logic [CPU_AW-1:0] cpu_addr;
  cpu_word_u         cpu_wdata;
  logic              cpu_ack;
  cpu_word_u         cpu_rdata;

  // Free list in order, pointers held by the client, RAM image
  fl_ptr_t model_q [$];
  fl_ptr_t in_use [$];
  fl_ptr_t model_ram [RAM_DEPTH];
  fl_idx_t model_tail;
  fl_ptr_t saved_ptr;

  fl_top UUT (.*);

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic end_in_failure(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic fail_value(input string msg);
    end_in_failure($sformatf("[FAIL] %0t ns: %s", $time, msg));
  endtask

  task automatic check_ptr(input fl_ptr_t got, input fl_ptr_t exp, input string what);
    if (got !== exp) begin
      fail_value($sformatf("%s got %0d expected %0d", what, got, exp));
    end
  endtask

  task automatic check_cnt(input fl_cnt_t got, input fl_cnt_t exp, input string what);
    if (got !== exp) begin
      fail_value($sformatf("%s got %0d expected %0d", what, got, exp));
    end
  endtask

  task automatic check_word(input cpu_word_u got, input cpu_word_u exp, input string what);
    if (got !== exp) begin
      fail_value($sformatf("%s got 0x%h expected 0x%h", what, got, exp));
    end
  endtask

  task automatic next_drive();
    @(posedge clk);
    #DRV;
  endtask

  // Hold pop until it is taken, or check that nothing comes out of an empty list
  task automatic do_pop();
    int   waited;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    next_drive();
    pop = 1'b1;
    while (!taken && !(model_q.size() == 0 && waited == EMPTY_HOLD)) begin
      @(negedge clk);
      if (pop_vld && model_q.size() == 0) begin
        fail_value("pop_vld high while no pointer is free");
      end else if (pop_vld) begin
        check_ptr(pop_ptr, model_q[0], "pop_ptr");
        in_use.push_back(model_q.pop_front());
        taken = 1'b1;
      end else if (waited == POP_WAIT) begin
        end_in_failure("Timed out waiting for pop_vld while free pointers remain");
      end
      waited++;
      next_drive();
    end
    pop = 1'b0;
    @(negedge clk);
    check_cnt(free_cnt, fl_cnt_t'(model_q.size()), "free_cnt after pop");
  endtask

  // Return a random pointer held by the client, optionally with a pop in the same cycle
  task automatic do_push(input logic with_pop);
    int      pick;
    fl_ptr_t ptr;
    if (in_use.size() == 0) begin
      end_in_failure("Stimulus table pushes more pointers than the client holds");
    end
    pick = $urandom_range(in_use.size() - 1, 0);
    ptr  = in_use[pick];
    in_use.delete(pick);
    next_drive();
    push     = 1'b1;
    push_ptr = ptr;
    pop      = with_pop;
    @(negedge clk);
    if (!ready) begin
      fail_value("ready low while a push is driven");
    end
    if (with_pop) begin
      if (!pop_vld) begin
        fail_value("pop_vld low on a pop paired with a push");
      end
      check_ptr(pop_ptr, model_q[0], "pop_ptr");
      in_use.push_back(model_q.pop_front());
    end
    model_q.push_back(ptr);
    model_ram[model_tail] = ptr;
    model_tail = model_tail + fl_idx_t'(1);
    next_drive();
    push = 1'b0;
    pop  = 1'b0;
    @(negedge clk);
    check_cnt(free_cnt, fl_cnt_t'(model_q.size()), "free_cnt after push");
  endtask

  task automatic cpu_access(input logic wr, input logic entry, input fl_idx_t idx,
                            input cpu_word_u wdata, output cpu_word_u rdata);
    int waited;
    next_drive();
    cpu_req   = 1'b1;
    cpu_wr    = wr;
    cpu_addr  = {entry ? REG_ENTRY : REG_FREECNT, idx};
    cpu_wdata = wdata;
    waited    = 0;
    @(negedge clk);
    while (!cpu_ack) begin
      if (waited == ACK_WAIT) begin
        end_in_failure("Timed out waiting for cpu_ack to rise");
      end
      waited++;
      @(negedge clk);
    end
    rdata = cpu_rdata;
    next_drive();
    cpu_req = 1'b0;
    waited  = 0;
    @(negedge clk);
    while (cpu_ack) begin
      if (waited == ACK_WAIT) begin
        end_in_failure("Timed out waiting for cpu_ack to fall");
      end
      waited++;
      @(negedge clk);
    end
  endtask

  task automatic run_op(input op_t op);
    cpu_word_u word;
    cpu_word_u exp;
    exp = '0;
    case (op.kind)
      OP_POP:      do_pop();
      OP_PUSH:     do_push(1'b0);
      OP_POP_PUSH: do_push(1'b1);
      OP_CNT_RD: begin
        cpu_access(1'b0, 1'b0, '0, '0, word);
        exp.as_cnt.cnt = fl_cnt_t'(model_q.size());
        check_word(word, exp, "free count register");
      end
      OP_ENT_RD: begin
        cpu_access(1'b0, 1'b1, op.idx, '0, word);
        exp.as_ptr.ptr = model_ram[op.idx];
        check_word(word, exp, "RAM entry");
      end
      default: begin
        if (op.restore) begin
          exp.as_ptr.ptr = saved_ptr;
        end else begin
          saved_ptr      = model_ram[op.idx];
          exp.as_ptr.ptr = op.ptr;
        end
        model_ram[op.idx] = exp.as_ptr.ptr;
        cpu_access(1'b1, 1'b1, op.idx, exp, word);
      end
    endcase
  endtask

  function automatic int run_budget();
    int cycles;
    cycles = 8 + RAM_DEPTH + 2;
    foreach (OPS[i]) begin
      cycles += int'(OPS[i].rep) * (2 * ACK_WAIT + 6);
    end
    return cycles;
  endfunction

  initial begin
    #(run_budget() * CLK_PERIOD);
    end_in_failure($sformatf("Watchdog expired after %0d cycles, the run hung", run_budget()));
  end

  initial begin
    int waited;
    void'($urandom(71157));
    rstvld    = 1'b1;
    // Pop held through reset must not be answered
    pop       = 1'b1;
    push      = 1'b0;
    push_ptr  = '0;
    cpu_req   = 1'b0;
    cpu_wr    = 1'b0;
    cpu_addr  = '0;
    cpu_wdata = '0;
    // Init loads entry i with pointer i, and the list starts in that order
    for (int i = 0; i < NUM_PTR; i++) begin
      model_q.push_back(fl_ptr_t'(i));
      model_ram[i] = fl_ptr_t'(i);
    end
    model_tail = '0;
    saved_ptr  = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    if (ready || pop_vld || cpu_ack) begin
      fail_value("ready, pop_vld or cpu_ack high during reset");
    end
    next_drive();
    rstvld = 1'b0;
    pop    = 1'b0;
    waited = 0;
    @(negedge clk);
    while (!ready) begin
      if (waited == RAM_DEPTH + 2) begin
        end_in_failure("ready did not rise after the init sequence");
      end
      waited++;
      @(negedge clk);
    end
    check_cnt(free_cnt, fl_cnt_t'(NUM_PTR), "free_cnt after init");
    foreach (OPS[i]) begin
      for (int n = 0; n < int'(OPS[i].rep); n++) begin
        repeat ($urandom_range(2, 0)) @(posedge clk);
        run_op(OPS[i]);
      end
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- fl_top.f
hdl/fl_cfg_pkg.sv
hdl/fl_cpu_pkg.sv
hdl/fl_ptr_ram.sv
hdl/fl_level_cnt.sv
hdl/fl_prefetch.sv
hdl/fl_ram_access.sv
hdl/fl_ctrl_fsm.sv
hdl/fl_top.sv
tb/fl_top_tb.sv

//--- Makefile
SRCS := $(wildcard hdl/*.sv) $(wildcard tb/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vfl_top_tb: fl_top.f $(SRCS)
	verilator --binary --timing --assert --top-module fl_top_tb \
		-f fl_top.f -Mdir obj_dir -o Vfl_top_tb

# A failing run ends in $fatal, so the exit status carries the result
run: obj_dir/Vfl_top_tb
	./obj_dir/Vfl_top_tb

clean:
	rm -rf obj_dir
